// File: dv/mathGolden.txt
# test class(0 add, 1 mul) a(hex) b(hex) dest result(hex) outStall
# One record per operation, records of a test are grouped by the first column
1 0 0012 0034 1 0046 0
1 1 0003 0005 2 000F 0
1 0 FFFF 0001 3 0000 0
1 1 0123 0010 4 1230 0
1 0 7FFF 7FFF 5 FFFE 0
1 1 FFFF FFFF 6 0001 0
1 0 1234 4321 7 5555 0
1 1 00FF 0101 8 FFFF 0
2 1 0002 0003 9 0006 1
2 0 0010 0020 10 0030 1
2 1 0011 0011 11 0121 1
2 0 ABCD 1111 12 BCDE 1
2 0 0001 0002 13 0003 1
2 1 1000 0010 14 0000 1
2 1 0007 0009 15 003F 1
2 0 F000 2000 16 1000 1
3 1 0001 0001 17 0001 1
3 1 0002 0002 18 0004 1
3 1 0003 0003 19 0009 1
3 1 0004 0004 20 0010 1
3 1 0005 0005 21 0019 1
3 1 0006 0006 22 0024 1
3 1 0007 0007 23 0031 1
3 1 0008 0008 24 0040 1
3 1 0009 0009 25 0051 1
4 0 0005 0006 26 000B 0
4 1 0004 0040 27 0100 1
4 0 8000 8000 28 0000 1
4 1 0013 0003 29 0039 0
4 0 0FF0 000F 30 0FFF 1
4 1 0021 0021 31 0441 0

// File: dv/mathUnitTb.sv
// Testbench for the math stage driven by golden operation records
`timescale 1ns/1ps

`include "tpuMath_defs.svh"

module mathUnitTb
	import tpuDataPkg::*, tpuOpPkg::*;
();

	typedef struct packed {
		dataWord result;
		regIndex dest;
		int seq;          // Absolute acceptance order
		int acceptCycle;
	} tokenEntry;

	logic clock = 1'b0;
	logic reset;
	logic inValid;
	opClass inClass;
	dataWord inA;
	dataWord inB;
	regIndex inDest;
	logic outStall;
	logic busy;
	logic outValid;
	opClass outClass;
	dataWord outResult;
	regIndex outDest;
	issueNo outIssue;

	// Golden records
	int recTest[$];
	opClass recClass[$];
	dataWord recA[$];
	dataWord recB[$];
	regIndex recDest[$];
	dataWord recResult[$];
	logic recStall[$];
	int numRecords = 0;
	int watchLimit = 0;

	// Scoreboard with one queue per class
	tokenEntry mulQ[$];
	tokenEntry addQ[$];
	dataWord curResult;  // Expected result of the op on the inputs
	int cycle = 0;
	int acceptCount = 0;
	int releaseCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int busyHits = 0;
	int ageConflicts = 0;

	mathUnit dut (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.inClass(inClass),
		.inA(inA),
		.inB(inB),
		.inDest(inDest),
		.outStall(outStall),
		.busy(busy),
		.outValid(outValid),
		.outClass(outClass),
		.outResult(outResult),
		.outDest(outDest),
		.outIssue(outIssue)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		if (!reset)
			cycle <= cycle + 1;
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic checkData(input dataWord got, input dataWord exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkReg(input regIndex got, input regIndex exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkIssue(input issueNo got, input issueNo exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkClass(input opClass got, input opClass exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Golden file and stimulus
	//////////////////////////////////////////////////

	task automatic readGolden();
		int fd;
		int code;
		int t;
		int c;
		int d;
		int s;
		dataWord a;
		dataWord b;
		dataWord r;
		string line;
		fd = $fopen("dv/mathGolden.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0)
				break;
			code = $sscanf(line, "%d %d %h %h %d %h %d", t, c, a, b, d, r, s);
			if (code == 7) begin  // Comment and blank lines fall through
				recTest.push_back(t);
				recClass.push_back((c == 1) ? classMul : classAdd);
				recA.push_back(a);
				recB.push_back(b);
				recDest.push_back(regIndex'(d));
				recResult.push_back(r);
				recStall.push_back(s != 0);
				// Sum or truncated product
				if (r !== ((c == 1) ? dataWord'(a * b) : dataWord'(a + b))) begin
					errorCount++;
					$display("golden record %0d has a result that does not match its operands",
						numRecords);
				end
				numRecords++;
			end
		end
		$fclose(fd);
	endtask

	// Holds the op on the inputs until busy lets it through
	task automatic driveOp(input int i);
		logic accepted;
		logic dropStall;
		inValid = 1'b1;
		inClass = recClass[i];
		inA = recA[i];
		inB = recB[i];
		inDest = recDest[i];
		curResult = recResult[i];
		outStall = recStall[i];
		accepted = 1'b0;
		while (!accepted) begin
			dropStall = 1'b0;
			@(negedge clock);
			if (!busy) begin
				accepted = 1'b1;
			end else if (outStall) begin
				busyHits++;
				dropStall = 1'b1;  // A full queue under stall never drains
			end
			@(posedge clock);
			#1;
			if (dropStall)
				outStall = 1'b0;
		end
		inValid = 1'b0;
	endtask

	task automatic finishTest(input int id, input int ops, input int errorsBefore);
		// Let every head finish while the stall level stays put
		repeat (`MLT_DEPTH + 2) @(posedge clock);
		#1;
		outStall = 1'b0;
		while (mulQ.size() + addQ.size() != 0)
			@(posedge clock);
		@(posedge clock);
		#1;
		$display("test %0d: %0d ops, %0d errors, %s", id, ops, errorCount - errorsBefore,
			(errorCount == errorsBefore) ? "ok" : "mismatch");
	endtask

	//////////////////////////////////////////////////
	// Scoreboard sampled mid-cycle
	//////////////////////////////////////////////////

	always @(negedge clock) begin
		tokenEntry entry;
		logic mulFin;
		logic addFin;
		logic expBusy;
		opClass pick;
		if (!reset) begin
			// Full counts the token still on the strobe
			expBusy = (inClass == classMul) ? (mulQ.size() == `MLT_DEPTH) :
				(addQ.size() == `ADD_DEPTH);
			checkFlag(busy, expBusy, "busy");
			mulFin = (mulQ.size() > 0) && (cycle - mulQ[0].acceptCycle >= `MLT_DEPTH + 1);
			addFin = (addQ.size() > 0) && (cycle - addQ[0].acceptCycle >= `ADD_DEPTH + 1);
			checkFlag(outValid, (mulFin | addFin) & ~outStall, "outValid");
			if (outValid)
				releaseCount++;
			if (outValid && (mulFin || addFin)) begin
				if (mulFin && addFin) begin
					ageConflicts++;
					pick = (mulQ[0].seq < addQ[0].seq) ? classMul : classAdd;  // Older first
				end else begin
					pick = mulFin ? classMul : classAdd;
				end
				checkClass(outClass, pick, "outClass");
				if (pick == classMul)
					entry = mulQ.pop_front();
				else
					entry = addQ.pop_front();
				checkData(outResult, entry.result, "outResult");
				checkReg(outDest, entry.dest, "outDest");
				checkIssue(outIssue, issueNo'(entry.seq), "outIssue");
			end
			if (inValid && !busy) begin
				entry.result = curResult;
				entry.dest = inDest;
				entry.seq = acceptCount;
				entry.acceptCycle = cycle;
				if (inClass == classMul)
					mulQ.push_back(entry);
				else
					addQ.push_back(entry);
				acceptCount++;
			end
		end
	end

	initial begin
		wait (watchLimit > 0);
		repeat (watchLimit) @(posedge clock);
		$display("timeout: the run did not finish within %0d cycles", watchLimit);
		$display("tests failed");
		$finish;
	end

	initial begin
		int prevTest;
		int testOps;
		int errorsBefore;
		int testCount;
		reset = 1'b1;
		inValid = 1'b0;
		inClass = classAdd;
		inA = '0;
		inB = '0;
		inDest = '0;
		outStall = 1'b0;
		curResult = '0;
		readGolden();
		if (numRecords == 0) begin
			$display("no records could be read from dv/mathGolden.txt");
			$display("tests failed");
			$finish;
		end else begin
			watchLimit = numRecords * (`MLT_DEPTH + 20);
			repeat (4) @(posedge clock);
			#1;
			reset = 1'b0;
			prevTest = recTest[0];
			testOps = 0;
			errorsBefore = errorCount;
			testCount = 0;
			for (int i = 0; i < numRecords; i++) begin
				if (recTest[i] != prevTest) begin
					finishTest(prevTest, testOps, errorsBefore);
					testCount++;
					prevTest = recTest[i];
					testOps = 0;
					errorsBefore = errorCount;
				end
				driveOp(i);
				testOps++;
			end
			finishTest(prevTest, testOps, errorsBefore);
			testCount++;
			if (releaseCount != acceptCount) begin
				errorCount++;
				$display("%0d tokens left the pipe for %0d accepted ops", releaseCount, acceptCount);
			end
			if (busyHits == 0) begin
				errorCount++;
				$display("busy never rose while the output was stalled");
			end
			if (ageConflicts == 0) begin
				errorCount++;
				$display("both queue heads were never finished at the same time");
			end
			$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
			if (errorCount == 0)
				$display("all tests passed");
			else
				$display("tests failed");
			$finish;
		end
	end

endmodule

// File: hdl/mathIssue.sv
// Issue stage that accepts operations, stamps issue numbers and computes results
`timescale 1ns/1ps

module mathIssue
	import tpuDataPkg::*, tpuOpPkg::*;
(
	input logic clock,
	input logic reset,
	input logic inValid,
	input opClass inClass,
	input dataWord inA,
	input dataWord inB,
	input regIndex inDest,
	input logic mlFull,
	input logic adFull,
	output logic busy,
	output logic tokenValid,
	output opClass tokenClass,
	output dataWord tokenResult,
	output regIndex tokenDest,
	output issueNo tokenIssue
);

	issueState state;
	issueNo issueCount;  // Number given to the next accepted op
	logic accept;
	dataWord result;

	//////////////////////////////////////////////////
	// Acceptance
	//////////////////////////////////////////////////

	// Only the queue of the requested class matters
	assign busy = (inClass == classMul) ? mlFull : adFull;
	assign accept = inValid & ~busy;

	// Product keeps only its low half
	assign result = (inClass == classMul) ? inA * inB : inA + inB;

	//////////////////////////////////////////////////
	// Token strobe FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: if (accept) state <= issued;
				issued: if (!accept) state <= idle;  // Back-to-back ops stay here
				default: state <= idle;
			endcase
		end
	end

	assign tokenValid = (state == issued);

	always_ff @(posedge clock) begin
		if (reset)
			issueCount <= '0;
		else if (accept)
			issueCount <= issueCount + 1'b1;
	end

	// Payload follows the strobe
	always_ff @(posedge clock) begin
		if (accept) begin
			tokenClass <= inClass;
			tokenResult <= result;
			tokenDest <= inDest;
			tokenIssue <= issueCount;
		end
	end

endmodule

// File: hdl/mathTokenPipe.sv
// Latency queues per class with age-ordered release of finished tokens
`timescale 1ns/1ps

`include "tpuMath_defs.svh"

module mathTokenPipe
	import tpuDataPkg::*, tpuOpPkg::*;
(
	input logic clock,
	input logic reset,
	input logic tokenValid,
	input opClass tokenClass,
	input dataWord tokenResult,
	input regIndex tokenDest,
	input issueNo tokenIssue,
	input logic outStall,
	output logic mlFull,
	output logic adFull,
	output logic outValid,
	output opClass outClass,
	output dataWord outResult,
	output regIndex outDest,
	output issueNo outIssue
);

	cycleStamp cycleCount;
	issueNo nextIssue;     // Reference point for head ages

	// Per-class head view, indexed by opClass
	logic [1:0] headFinished;
	logic [1:0] fullLevel;
	logic [1:0] pop;
	dataWord headResult [2];
	regIndex headDest [2];
	issueNo headIssue [2];
	queueCount occupancy [2];

	issueNo mulAge;
	issueNo addAge;
	logic pickMul;

	always_ff @(posedge clock) begin
		if (reset) begin
			cycleCount <= '0;
			nextIssue <= '0;
		end else begin
			cycleCount <= cycleCount + 1'b1;
			if (tokenValid)
				nextIssue <= tokenIssue + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Latency queues, one per class
	//////////////////////////////////////////////////

	for (genvar cls = 0; cls < 2; cls++) begin : gQueue
		localparam int depth = (cls == int'(classMul)) ? `MLT_DEPTH : `ADD_DEPTH;
		localparam int addrWidth = (depth > 1) ? $clog2(depth) : 1;
		localparam int countWidth = $clog2(depth + 1);

		logic write;
		logic full;
		logic empty;
		logic [addrWidth-1:0] writeAddr;
		logic [addrWidth-1:0] readAddr;
		logic [countWidth-1:0] count;
		logic [depth-1:0] done;  // Sticky, release cycle already passed

		dataWord resultMem [depth];
		regIndex destMem [depth];
		issueNo issueMem [depth];
		cycleStamp releaseMem [depth];

		assign write = tokenValid & (tokenClass == opClass'(cls));

		ringBufferControl #(
			.numEntry(depth)
		) ringCtrl (
			.clock(clock),
			.reset(reset),
			.write(write),
			.read(pop[cls]),
			.writeAddr(writeAddr),
			.readAddr(readAddr),
			.full(full),
			.empty(empty),
			.count(count)
		);

		always_ff @(posedge clock) begin
			if (write) begin
				resultMem[writeAddr] <= tokenResult;
				destMem[writeAddr] <= tokenDest;
				issueMem[writeAddr] <= tokenIssue;
				releaseMem[writeAddr] <= cycleCount + cycleStamp'(depth);
			end
		end

		// Keeps a finished entry finished through long stalls
		always_ff @(posedge clock) begin
			if (reset) begin
				done <= '0;
			end else begin
				for (int i = 0; i < depth; i++) begin
					if (write && (writeAddr == addrWidth'(i)))
						done[i] <= 1'b0;
					else if (cycleCount == releaseMem[i])
						done[i] <= 1'b1;
				end
			end
		end

		assign headFinished[cls] = ~empty &
			(done[readAddr] | (cycleCount == releaseMem[readAddr]));
		assign headResult[cls] = resultMem[readAddr];
		assign headDest[cls] = destMem[readAddr];
		assign headIssue[cls] = issueMem[readAddr];
		assign occupancy[cls] = queueCount'(count);

		// Counts the token already on the strobe
		assign fullLevel[cls] = full |
			(write & (occupancy[cls] == queueCount'(depth - 1)));

		// A stalled head must not lose its finished state
		assert property (@(posedge clock) disable iff (reset)
			headFinished[cls] && outStall |=> headFinished[cls])
			else $error("mathTokenPipe: finished head dropped during stall");
	end

	assign mlFull = fullLevel[classMul];
	assign adFull = fullLevel[classAdd];

	//////////////////////////////////////////////////
	// Age arbitration and release
	//////////////////////////////////////////////////

	assign mulAge = nextIssue - headIssue[classMul];
	assign addAge = nextIssue - headIssue[classAdd];

	// Larger age means issued earlier
	assign pickMul = headFinished[classMul] &
		(~headFinished[classAdd] | (mulAge > addAge));

	assign outValid = (|headFinished) & ~outStall;
	assign pop = {outValid & pickMul, outValid & ~pickMul};

	assign outClass = pickMul ? classMul : classAdd;
	assign outResult = headResult[pickMul];
	assign outDest = headDest[pickMul];
	assign outIssue = headIssue[pickMul];

endmodule

// File: hdl/mathUnit.sv
// Math execution stage top joining the issue stage and the token pipe
`timescale 1ns/1ps

module mathUnit
	import tpuDataPkg::*, tpuOpPkg::*;
(
	input logic clock,
	input logic reset,
	input logic inValid,
	input opClass inClass,
	input dataWord inA,
	input dataWord inB,
	input regIndex inDest,
	input logic outStall,
	output logic busy,
	output logic outValid,
	output opClass outClass,
	output dataWord outResult,
	output regIndex outDest,
	output issueNo outIssue
);

	// Issue stage to token pipe
	logic tokenValid;
	opClass tokenClass;
	dataWord tokenResult;
	regIndex tokenDest;
	issueNo tokenIssue;
	logic mlFull;
	logic adFull;

	mathIssue issue (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.inClass(inClass),
		.inA(inA),
		.inB(inB),
		.inDest(inDest),
		.mlFull(mlFull),
		.adFull(adFull),
		.busy(busy),
		.tokenValid(tokenValid),
		.tokenClass(tokenClass),
		.tokenResult(tokenResult),
		.tokenDest(tokenDest),
		.tokenIssue(tokenIssue)
	);

	mathTokenPipe tokenPipe (
		.clock(clock),
		.reset(reset),
		.tokenValid(tokenValid),
		.tokenClass(tokenClass),
		.tokenResult(tokenResult),
		.tokenDest(tokenDest),
		.tokenIssue(tokenIssue),
		.outStall(outStall),
		.mlFull(mlFull),
		.adFull(adFull),
		.outValid(outValid),
		.outClass(outClass),
		.outResult(outResult),
		.outDest(outDest),
		.outIssue(outIssue)
	);

endmodule

// File: hdl/ringBufferControl.sv
// Pointer and occupancy control for one circular queue of any depth
`timescale 1ns/1ps

module ringBufferControl #(
	parameter int numEntry = 4,
	localparam int addrWidth = (numEntry > 1) ? $clog2(numEntry) : 1,
	localparam int countWidth = $clog2(numEntry + 1)
) (
	input logic clock,
	input logic reset,
	input logic write,
	input logic read,
	output logic [addrWidth-1:0] writeAddr,
	output logic [addrWidth-1:0] readAddr,
	output logic full,
	output logic empty,
	output logic [countWidth-1:0] count
);

	localparam logic [addrWidth-1:0] lastAddr = addrWidth'(numEntry - 1);

	// Depth need not be a power of two, so wrap explicitly
	function automatic logic [addrWidth-1:0] advance(input logic [addrWidth-1:0] ptr);
		return (ptr == lastAddr) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			writeAddr <= '0;
			readAddr <= '0;
			count <= '0;
		end else begin
			if (write)
				writeAddr <= advance(writeAddr);
			if (read)
				readAddr <= advance(readAddr);
			case ({write, read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

	assign full = (count == countWidth'(numEntry));
	assign empty = (count == '0);

	// Callers must hold off on their own
	assert property (@(posedge clock) disable iff (reset) write |-> !full)
		else $error("ringBufferControl: write while full");
	assert property (@(posedge clock) disable iff (reset) read |-> !empty)
		else $error("ringBufferControl: read while empty");

endmodule

// File: hdl/tpuDataPkg.sv
// Data, issue and queue occupancy types for the math stage
package tpuDataPkg;

`include "tpuMath_defs.svh"

	//////////////////////////////////////////////////
	// Payload fields
	//////////////////////////////////////////////////

	typedef logic [`DATA_WIDTH-1:0] dataWord;    // Operand or result
	typedef logic [`REG_WIDTH-1:0] regIndex;     // Destination register
	typedef logic [`ISSUE_WIDTH-1:0] issueNo;    // Wraps, compared by difference

	//////////////////////////////////////////////////
	// Timing and occupancy
	//////////////////////////////////////////////////

	// Free-running cycle count for release times
	typedef logic [7:0] cycleStamp;

	// Deeper of the two latency queues
	localparam int maxDepth = (`MLT_DEPTH > `ADD_DEPTH) ? `MLT_DEPTH : `ADD_DEPTH;

	// Wide enough for the fill level of either queue
	typedef logic [$clog2(maxDepth + 1)-1:0] queueCount;

endpackage

// File: hdl/tpuMath_defs.svh
// Math stage sizing macros shared by packages and RTL
`ifndef TPU_MATH_DEFS_SVH
`define TPU_MATH_DEFS_SVH

//////////////////////////////////////////////////
// Latencies and queue depths
//////////////////////////////////////////////////

// Multiply latency, also the multiply queue depth
`define MLT_DEPTH 7

// Add latency, also the add queue depth
`define ADD_DEPTH 5

//////////////////////////////////////////////////
// Field widths
//////////////////////////////////////////////////

`define ISSUE_WIDTH 6   // Wrapping issue number
`define DATA_WIDTH 16   // Operands and results
`define REG_WIDTH 5     // Destination register index

`endif

// File: hdl/tpuOpPkg.sv
// Operation class and issue state encodings for the math stage
package tpuOpPkg;

	//////////////////////////////////////////////////
	// Operation class
	//////////////////////////////////////////////////

	// Value doubles as the queue index in the token pipe
	typedef enum logic {
		classAdd = 1'b0,
		classMul = 1'b1
	} opClass;

	//////////////////////////////////////////////////
	// Issue stage FSM
	//////////////////////////////////////////////////

	typedef enum logic {
		idle   = 1'b0,  // No token on the strobe
		issued = 1'b1   // Token valid this cycle
	} issueState;

endpackage

// File: list.f
+incdir+hdl
hdl/tpuDataPkg.sv
hdl/tpuOpPkg.sv
hdl/ringBufferControl.sv
hdl/mathIssue.sv
hdl/mathTokenPipe.sv
hdl/mathUnit.sv
dv/mathUnitTb.sv

// File: run.sh
#!/bin/sh
# Builds the math stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
PASS_TEXT="all tests passed"

verilator --binary --timing --assert \
	-f list.f \
	--top-module mathUnitTb \
	-Mdir "$BUILD_DIR" \
	-o mathUnitSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/mathUnitSim" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "$PASS_TEXT" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
